// File: Makefile
VERILATOR ?= verilator
TOP       ?= mem_wb_tb
RTL_TOP   ?= mem_wb_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
RTL_FILES ?= design/rv32i_types_pkg.sv design/pipe_cfg_pkg.sv design/mem_stage.sv \
             design/data_mem.sv design/wb_queue.sv design/wb_stage.sv design/mem_wb_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	-$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: all.f
design/rv32i_types_pkg.sv
design/pipe_cfg_pkg.sv
design/mem_stage.sv
design/data_mem.sv
design/wb_queue.sv
design/wb_stage.sv
design/mem_wb_top.sv
tests/mem_wb_props.sv
tests/mem_wb_tb.sv

// File: design/data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem (
    input  wire logic                            clk,
    input  wire logic                            arst_n,
    input  wire logic                            dmem_req,
    input  wire logic                            dmem_we,
    input  wire rv32i_types_pkg::word_t          dmem_addr,
    input  wire rv32i_types_pkg::byte_mask_t     dmem_wmask,
    input  wire rv32i_types_pkg::word_t          dmem_wdata,
    output rv32i_types_pkg::word_t               dmem_rdata,
    output logic                                 dmem_resp
);

    rv32i_types_pkg::word_t  mem [pipe_cfg_pkg::DMEM_WORDS];
    pipe_cfg_pkg::dmem_idx_t idx;

    assign idx = dmem_addr[pipe_cfg_pkg::DMEM_AW+1:2]; // word address.

    initial begin
        for (int i = 0; i < pipe_cfg_pkg::DMEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (dmem_req) begin
            if (dmem_we) begin
                for (int b = 0; b < 4; b++) begin
                    if (dmem_wmask[b]) begin
                        mem[idx][8*b +: 8] <= dmem_wdata[8*b +: 8];
                    end
                end
            end else begin
                dmem_rdata <= mem[idx];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dmem_resp <= 1'b0;
        end else begin
            dmem_resp <= dmem_req; // stores answer too.
        end
    end

endmodule

`default_nettype wire

// File: design/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  wire logic                            clk,
    input  wire logic                            arst_n,
    input  wire pipe_cfg_pkg::ex_mem_stage_reg_t ex_mem,
    input  wire logic                            ex_valid,
    output logic                                 ex_ready,
    output logic                                 dmem_req,
    output logic                                 dmem_we,
    output rv32i_types_pkg::word_t               dmem_addr,
    output rv32i_types_pkg::byte_mask_t          dmem_wmask,
    output rv32i_types_pkg::word_t               dmem_wdata,
    input  wire rv32i_types_pkg::word_t          dmem_rdata,
    input  wire logic                            dmem_resp,
    input  wire logic                            credit_return,
    output logic                                 q_push,
    output pipe_cfg_pkg::mem_wb_stage_reg_t      q_data
);

    pipe_cfg_pkg::credit_t           credits;
    pipe_cfg_pkg::ex_mem_stage_reg_t stage_q;
    logic                            stage_valid;
    logic                            accept;
    logic                            is_bubble;
    logic [1:0]                      lane;

    assign ex_ready  = (credits != '0); // a credit is free.
    assign accept    = ex_valid & ex_ready;
    assign is_bubble = (ex_mem.pc == '0);
    assign lane      = ex_mem.alu_out[1:0];

    // access issued in the handshake cycle.
    always_comb begin
        dmem_req   = accept & ~is_bubble &
                     (ex_mem.mem_signal.mem_read | ex_mem.mem_signal.mem_write);
        dmem_we    = ex_mem.mem_signal.mem_write;
        dmem_addr  = ex_mem.alu_out;
        dmem_wmask = '0;
        dmem_wdata = '0;
        if (ex_mem.mem_signal.mem_write) begin
            case (ex_mem.mem_signal.load_ops)
                rv32i_types_pkg::lb_mem, rv32i_types_pkg::lbu_mem: begin
                    dmem_wmask = 4'b0001 << lane;
                    dmem_wdata = ex_mem.rs2_v << {lane, 3'b000};
                end
                rv32i_types_pkg::lh_mem, rv32i_types_pkg::lhu_mem: begin
                    dmem_wmask = 4'b0011 << {lane[1], 1'b0};
                    dmem_wdata = ex_mem.rs2_v << {lane[1], 4'b0000};
                end
                default: begin
                    dmem_wmask = 4'b1111;
                    dmem_wdata = ex_mem.rs2_v;
                end
            endcase
        end
    end

    // one credit per accept, one back per pop.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credits <= pipe_cfg_pkg::credit_t'(pipe_cfg_pkg::QUEUE_DEPTH);
        end else begin
            case ({accept, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stage_valid <= 1'b0;
        end else begin
            stage_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            stage_q <= ex_mem;
        end
    end

    // read data lands while the record sits in the stage register.
    always_comb begin
        q_push            = stage_valid;
        q_data.pc         = stage_q.pc;
        q_data.order      = stage_q.order;
        q_data.mem_signal = stage_q.mem_signal;
        q_data.wb_signal  = stage_q.wb_signal;
        q_data.alu_out    = stage_q.alu_out;
        q_data.br_en      = stage_q.br_en;
        q_data.u_imm      = stage_q.u_imm;
        q_data.rd_s       = stage_q.rd_s;
        q_data.mem_addr   = stage_q.alu_out;
        q_data.dmem_rdata = dmem_resp ? dmem_rdata : '0;
    end

endmodule

`default_nettype wire

// File: design/mem_wb_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_top (
    input  wire logic                            clk,
    input  wire logic                            arst_n,
    input  wire pipe_cfg_pkg::ex_mem_stage_reg_t ex_mem,
    input  wire logic                            ex_valid,
    output logic                                 ex_ready,
    input  wire logic                            wb_stall,
    output logic                                 wb_valid,
    output rv32i_types_pkg::reg_idx_t            wb_rd_s,
    output rv32i_types_pkg::word_t               wb_rd_v,
    output logic                                 wb_regf_we,
    output rv32i_types_pkg::order_t              wb_order
);

    logic                            dmem_req;
    logic                            dmem_we;
    rv32i_types_pkg::word_t          dmem_addr;
    rv32i_types_pkg::byte_mask_t     dmem_wmask;
    rv32i_types_pkg::word_t          dmem_wdata;
    rv32i_types_pkg::word_t          dmem_rdata;
    logic                            dmem_resp;
    logic                            credit_return;
    logic                            q_push;
    pipe_cfg_pkg::mem_wb_stage_reg_t q_data;
    logic                            q_pop;
    pipe_cfg_pkg::mem_wb_stage_reg_t q_head;
    logic                            q_valid;

    mem_stage mem_stage_i (
        .clk, .arst_n, .ex_mem, .ex_valid, .ex_ready,
        .dmem_req, .dmem_we, .dmem_addr, .dmem_wmask, .dmem_wdata,
        .dmem_rdata, .dmem_resp, .credit_return, .q_push, .q_data
    );

    data_mem data_mem_i (
        .clk, .arst_n, .dmem_req, .dmem_we, .dmem_addr, .dmem_wmask,
        .dmem_wdata, .dmem_rdata, .dmem_resp
    );

    wb_queue wb_queue_i (
        .clk, .arst_n, .q_push, .q_data, .q_pop, .q_head, .q_valid,
        .credit_return
    );

    wb_stage wb_stage_i (
        .clk, .arst_n, .q_head, .q_valid, .wb_stall, .q_pop,
        .wb_valid, .wb_rd_s, .wb_rd_v, .wb_regf_we, .wb_order
    );

endmodule

`default_nettype wire

// File: design/pipe_cfg_pkg.sv
`default_nettype none

package pipe_cfg_pkg;

    localparam int QUEUE_DEPTH = 4; // queue entries and credits.
    localparam int DMEM_WORDS  = 256;

    localparam int CREDIT_W = $clog2(QUEUE_DEPTH + 1);
    localparam int PTR_W    = $clog2(QUEUE_DEPTH);
    localparam int DMEM_AW  = $clog2(DMEM_WORDS);

    typedef logic [CREDIT_W-1:0] credit_t;
    typedef logic [PTR_W-1:0]    q_ptr_t;
    typedef logic [DMEM_AW-1:0]  dmem_idx_t;

    // record handed from execute to the memory stage.
    typedef struct packed {
        rv32i_types_pkg::word_t       pc;
        rv32i_types_pkg::order_t      order;
        rv32i_types_pkg::mem_signal_t mem_signal;
        rv32i_types_pkg::wb_signal_t  wb_signal;
        rv32i_types_pkg::word_t       alu_out; // also the data address.
        rv32i_types_pkg::word_t       br_en;
        rv32i_types_pkg::word_t       u_imm;
        rv32i_types_pkg::reg_idx_t    rd_s;
        rv32i_types_pkg::word_t       rs2_v;
    } ex_mem_stage_reg_t;

    // record queued between memory and write-back.
    typedef struct packed {
        rv32i_types_pkg::word_t       pc;
        rv32i_types_pkg::order_t      order;
        rv32i_types_pkg::mem_signal_t mem_signal;
        rv32i_types_pkg::wb_signal_t  wb_signal;
        rv32i_types_pkg::word_t       alu_out;
        rv32i_types_pkg::word_t       br_en;
        rv32i_types_pkg::word_t       u_imm;
        rv32i_types_pkg::reg_idx_t    rd_s;
        rv32i_types_pkg::word_t       mem_addr;
        rv32i_types_pkg::word_t       dmem_rdata;
    } mem_wb_stage_reg_t;

endpackage

`default_nettype wire

// File: design/rv32i_types_pkg.sv
`default_nettype none

package rv32i_types_pkg;

    // data word, also used for addresses.
    typedef logic [31:0] word_t;

    // architectural register index.
    typedef logic [4:0] reg_idx_t;

    // one bit per byte lane.
    typedef logic [3:0] byte_mask_t;

    // retirement order counter.
    typedef logic [63:0] order_t;

    // access width and extension; stores reuse the width part.
    typedef enum logic [2:0] {
        lb_mem,
        lbu_mem,
        lh_mem,
        lhu_mem,
        lw_mem
    } load_ops_t;

    // register value source at write-back.
    typedef enum logic [2:0] {
        alu_out_wb,
        br_en_wb,
        u_imm_wb,
        load_wb,
        pc_plus4_wb
    } regf_m_sel_t;

    typedef struct packed {
        logic      mem_read;
        logic      mem_write;
        load_ops_t load_ops;
    } mem_signal_t;

    typedef struct packed {
        logic        regf_we;
        regf_m_sel_t regf_m_sel;
    } wb_signal_t;

endpackage

`default_nettype wire

// File: design/wb_queue.sv
`timescale 1ns/1ps
`default_nettype none

module wb_queue (
    input  wire logic                            clk,
    input  wire logic                            arst_n,
    input  wire logic                            q_push,
    input  wire pipe_cfg_pkg::mem_wb_stage_reg_t q_data,
    input  wire logic                            q_pop,
    output pipe_cfg_pkg::mem_wb_stage_reg_t      q_head,
    output logic                                 q_valid,
    output logic                                 credit_return
);

    pipe_cfg_pkg::mem_wb_stage_reg_t slots [pipe_cfg_pkg::QUEUE_DEPTH];
    pipe_cfg_pkg::q_ptr_t            wr_ptr;
    pipe_cfg_pkg::q_ptr_t            rd_ptr;
    pipe_cfg_pkg::credit_t           count;
    logic                            do_pop;

    assign q_valid = (count != '0);
    assign q_head  = slots[rd_ptr];
    assign do_pop  = q_pop & q_valid;

    // credits keep the queue from overflowing.
    always_ff @(posedge clk) begin
        if (q_push) begin
            slots[wr_ptr] <= q_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (q_push) begin
                wr_ptr <= wr_ptr + 1'b1; // power-of-two wrap.
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else begin
            case ({q_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credit_return <= 1'b0;
        end else begin
            credit_return <= do_pop; // slot freed last cycle.
        end
    end

endmodule

`default_nettype wire

// File: design/wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module wb_stage (
    input  wire logic                            clk,
    input  wire logic                            arst_n,
    input  wire pipe_cfg_pkg::mem_wb_stage_reg_t q_head,
    input  wire logic                            q_valid,
    input  wire logic                            wb_stall,
    output logic                                 q_pop,
    output logic                                 wb_valid,
    output rv32i_types_pkg::reg_idx_t            wb_rd_s,
    output rv32i_types_pkg::word_t               wb_rd_v,
    output logic                                 wb_regf_we,
    output rv32i_types_pkg::order_t              wb_order
);

    rv32i_types_pkg::word_t    load_v;
    rv32i_types_pkg::word_t    rd_v;
    rv32i_types_pkg::reg_idx_t rd_s;
    logic [7:0]                rbyte;
    logic [15:0]               rhalf;
    logic                      live;

    assign q_pop = q_valid & ~wb_stall;
    assign live  = (q_head.pc != '0); // pc zero marks a bubble.

    assign rbyte = q_head.dmem_rdata[{q_head.mem_addr[1:0], 3'b000} +: 8];
    assign rhalf = q_head.dmem_rdata[{q_head.mem_addr[1], 4'b0000} +: 16];

    always_comb begin
        case (q_head.mem_signal.load_ops)
            rv32i_types_pkg::lb_mem:  load_v = {{24{rbyte[7]}}, rbyte};
            rv32i_types_pkg::lbu_mem: load_v = {24'b0, rbyte};
            rv32i_types_pkg::lh_mem:  load_v = {{16{rhalf[15]}}, rhalf};
            rv32i_types_pkg::lhu_mem: load_v = {16'b0, rhalf};
            default:                  load_v = q_head.dmem_rdata;
        endcase
    end

    always_comb begin
        case (q_head.wb_signal.regf_m_sel)
            rv32i_types_pkg::alu_out_wb:  rd_v = q_head.alu_out;
            rv32i_types_pkg::br_en_wb:    rd_v = q_head.br_en;
            rv32i_types_pkg::u_imm_wb:    rd_v = q_head.u_imm;
            rv32i_types_pkg::load_wb:     rd_v = load_v;
            rv32i_types_pkg::pc_plus4_wb: rd_v = q_head.pc + 32'd4;
            default:                      rd_v = q_head.alu_out;
        endcase
        rd_s = q_head.mem_signal.mem_write ? '0 : q_head.rd_s; // stores write no register.
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid   <= 1'b0;
            wb_regf_we <= 1'b0;
        end else begin
            wb_valid   <= q_pop & live;
            wb_regf_we <= q_pop & live & q_head.wb_signal.regf_we;
        end
    end

    // payload follows the popped record.
    always_ff @(posedge clk) begin
        if (q_pop) begin
            wb_rd_s  <= rd_s;
            wb_rd_v  <= rd_v;
            wb_order <= q_head.order;
        end
    end

endmodule

`default_nettype wire

// File: tests/mem_wb_props.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_props (
    input wire logic                  clk,
    input wire logic                  arst_n,
    input wire pipe_cfg_pkg::credit_t credits,
    input wire pipe_cfg_pkg::credit_t q_count,
    input wire logic                  ex_ready,
    input wire logic                  q_push,
    input wire logic                  credit_return,
    input wire logic                  wb_valid,
    input wire logic                  wb_regf_we,
    input wire logic                  dmem_req
);

    localparam pipe_cfg_pkg::credit_t FULL =
        pipe_cfg_pkg::credit_t'(pipe_cfg_pkg::QUEUE_DEPTH);

    int fail_count = 0;

    credit_bound: assert property (@(posedge clk) disable iff (!arst_n) credits <= FULL)
        else begin $error("credit counter above queue depth"); fail_count++; end

    push_reserved: assert property (@(posedge clk) disable iff (!arst_n)
        q_push |-> credits < FULL)
        else begin $error("push without a reserved credit"); fail_count++; end

    // no credit left means every slot holds a record in flight.
    ready_credit: assert property (@(posedge clk) disable iff (!arst_n)
        !ex_ready == (int'(q_count) + int'(q_push) + int'(credit_return)
                      == pipe_cfg_pkg::QUEUE_DEPTH))
        else begin $error("ex_ready disagrees with the records in flight"); fail_count++; end

    // every slot is a credit, a queued record, a staged record or a returning credit.
    credit_conserve: assert property (@(posedge clk) disable iff (!arst_n)
        int'(credits) + int'(q_count) + int'(q_push) + int'(credit_return)
            == pipe_cfg_pkg::QUEUE_DEPTH)
        else begin $error("credits and queue occupancy out of balance"); fail_count++; end

    reset_quiet: assert property (@(posedge clk)
        !arst_n |-> !(wb_valid | wb_regf_we | q_push | credit_return | dmem_req))
        else begin $error("output active during reset"); fail_count++; end

endmodule

bind mem_wb_top mem_wb_props props_i (
    .clk,
    .arst_n,
    .credits(mem_stage_i.credits),
    .q_count(wb_queue_i.count),
    .ex_ready,
    .q_push,
    .credit_return,
    .wb_valid,
    .wb_regf_we,
    .dmem_req
);

`default_nettype wire

// File: tests/mem_wb_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_tb;

    localparam int TIMEOUT = 200;
    localparam int DEPTH   = pipe_cfg_pkg::QUEUE_DEPTH;

    typedef struct packed {
        rv32i_types_pkg::reg_idx_t rd_s;
        rv32i_types_pkg::word_t    rd_v;
        logic                      regf_we;
        rv32i_types_pkg::order_t   order;
    } wb_exp_t;

    logic                            clk = 1'b0;
    logic                            arst_n;
    pipe_cfg_pkg::ex_mem_stage_reg_t ex_mem;
    logic                            ex_valid;
    logic                            ex_ready;
    logic                            wb_stall = 1'b0;
    logic                            wb_valid;
    rv32i_types_pkg::reg_idx_t       wb_rd_s;
    rv32i_types_pkg::word_t          wb_rd_v;
    logic                            wb_regf_we;
    rv32i_types_pkg::order_t         wb_order;

    rv32i_types_pkg::word_t  shadow [pipe_cfg_pkg::DMEM_WORDS];
    wb_exp_t                 exp_q [$];
    wb_exp_t                 head;
    rv32i_types_pkg::order_t next_order = 64'd1;
    logic [31:0]             data_rng   = 32'd80857;
    logic [31:0]             stall_rng  = 32'd80857 ^ 32'h9e3779b9;
    int                      stall_mode = 0; // 0 low, 1 held, 2 random.
    int                      errors     = 0;
    int                      checks     = 0;
    string                   test_name  = "reset";

    mem_wb_top dut_i (
        .clk, .arst_n, .ex_mem, .ex_valid, .ex_ready, .wb_stall,
        .wb_valid, .wb_rd_s, .wb_rd_v, .wb_regf_we, .wb_order
    );

    always #2 clk = ~clk; // 4 ns period.

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] rand32();
        data_rng = xorshift32(data_rng);
        return data_rng;
    endfunction

    // load result as seen through the shadow copy.
    function automatic rv32i_types_pkg::word_t load_value(
        input rv32i_types_pkg::load_ops_t op,
        input rv32i_types_pkg::word_t     addr
    );
        rv32i_types_pkg::word_t w;
        logic [7:0]             b;
        logic [15:0]            h;
        w = shadow[addr[9:2]];
        b = 8'(w >> (8 * addr[1:0]));
        h = 16'(w >> (16 * addr[1]));
        case (op)
            rv32i_types_pkg::lb_mem:  return {{24{b[7]}}, b};
            rv32i_types_pkg::lbu_mem: return {24'h0, b};
            rv32i_types_pkg::lh_mem:  return {{16{h[15]}}, h};
            rv32i_types_pkg::lhu_mem: return {16'h0, h};
            default:                  return w;
        endcase
    endfunction

    task automatic store_shadow(
        input rv32i_types_pkg::load_ops_t op,
        input rv32i_types_pkg::word_t     addr,
        input rv32i_types_pkg::word_t     data
    );
        int idx;
        idx = int'(addr[9:2]);
        case (op)
            rv32i_types_pkg::lb_mem, rv32i_types_pkg::lbu_mem:
                shadow[idx][8*addr[1:0] +: 8] = data[7:0];
            rv32i_types_pkg::lh_mem, rv32i_types_pkg::lhu_mem:
                shadow[idx][16*addr[1] +: 16] = data[15:0];
            default:
                shadow[idx] = data;
        endcase
    endtask

    function automatic rv32i_types_pkg::word_t expected_rd_v(
        input pipe_cfg_pkg::ex_mem_stage_reg_t r
    );
        case (r.wb_signal.regf_m_sel)
            rv32i_types_pkg::br_en_wb:    return r.br_en;
            rv32i_types_pkg::u_imm_wb:    return r.u_imm;
            rv32i_types_pkg::load_wb:     return load_value(r.mem_signal.load_ops, r.alu_out);
            rv32i_types_pkg::pc_plus4_wb: return r.pc + 32'd4;
            default:                      return r.alu_out;
        endcase
    endfunction

    // live record without a memory access.
    function automatic pipe_cfg_pkg::ex_mem_stage_reg_t new_rec(
        input rv32i_types_pkg::regf_m_sel_t sel,
        input logic                         we
    );
        pipe_cfg_pkg::ex_mem_stage_reg_t r;
        logic [31:0]                     t;
        r = '0;
        t = rand32();
        r.pc                   = {16'h0001, t[15:2], 2'b00};
        r.br_en                = {31'h0, t[0]};
        r.u_imm                = {t[31:12], 12'h000};
        r.rd_s                 = t[11:7] | 5'd1;
        r.alu_out              = rand32();
        r.rs2_v                = rand32();
        r.wb_signal.regf_we    = we;
        r.wb_signal.regf_m_sel = sel;
        r.mem_signal.load_ops  = rv32i_types_pkg::lw_mem;
        return r;
    endfunction

    function automatic pipe_cfg_pkg::ex_mem_stage_reg_t mem_rec(
        input logic                       wr,
        input rv32i_types_pkg::load_ops_t op,
        input rv32i_types_pkg::word_t     addr
    );
        pipe_cfg_pkg::ex_mem_stage_reg_t r;
        r = new_rec(wr ? rv32i_types_pkg::alu_out_wb : rv32i_types_pkg::load_wb, ~wr);
        r.mem_signal.mem_read  = ~wr;
        r.mem_signal.mem_write = wr;
        r.mem_signal.load_ops  = op;
        r.alu_out              = addr;
        return r;
    endfunction

    task automatic report_mismatch(
        input string       field,
        input logic [63:0] expected,
        input logic [63:0] actual
    );
        $display("FAILED %s %s expected %0h actual %0h", test_name, field, expected, actual);
        errors++;
    endtask

    task automatic finish_run();
        int prop_fails;
        prop_fails = dut_i.props_i.fail_count;
        $display("checked %0d write-backs, %0d errors, %0d assertion failures",
                 checks, errors, prop_fails);
        if (errors == 0 && prop_fails == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    task automatic give_up(input string what);
        $display("timeout in test %s while waiting for %s", test_name, what);
        errors++;
        finish_run();
    endtask

    // expectation is queued before the accepting edge.
    task automatic send_rec(input pipe_cfg_pkg::ex_mem_stage_reg_t rec);
        pipe_cfg_pkg::ex_mem_stage_reg_t r;
        wb_exp_t                         e;
        int                              waited;
        r          = rec;
        r.order    = next_order;
        next_order = next_order + 64'd1;
        ex_mem     = r;
        ex_valid   = 1'b1;
        waited     = 0;
        while (!ex_ready) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                give_up("ex_ready");
            end
        end
        if (r.pc != '0) begin
            e.rd_s    = r.mem_signal.mem_write ? '0 : r.rd_s;
            e.rd_v    = expected_rd_v(r);
            e.regf_we = r.wb_signal.regf_we;
            e.order   = r.order;
            exp_q.push_back(e);
            if (r.mem_signal.mem_write) begin
                store_shadow(r.mem_signal.load_ops, r.alu_out, r.rs2_v);
            end
        end
        @(negedge clk);
        ex_valid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        stall_mode = 0;
        waited     = 0;
        while (exp_q.size() != 0 || !ex_ready) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                give_up("the write-back queue to drain");
            end
        end
    endtask

    task automatic send_random_op();
        logic [31:0]                     t;
        rv32i_types_pkg::word_t          a;
        rv32i_types_pkg::load_ops_t      op;
        rv32i_types_pkg::regf_m_sel_t    sel;
        pipe_cfg_pkg::ex_mem_stage_reg_t r;
        t = rand32();
        a = {22'h0, t[9:0]};
        case (t[28:26])
            3'd0:    op = rv32i_types_pkg::lb_mem;
            3'd1:    op = rv32i_types_pkg::lbu_mem;
            3'd2:    op = rv32i_types_pkg::lh_mem;
            3'd3:    op = rv32i_types_pkg::lhu_mem;
            default: op = rv32i_types_pkg::lw_mem;
        endcase
        if (op == rv32i_types_pkg::lh_mem || op == rv32i_types_pkg::lhu_mem) begin
            a[0] = 1'b0;
        end
        if (op == rv32i_types_pkg::lw_mem) begin
            a[1:0] = 2'b00;
        end
        case (t[25:24])
            2'd0:    sel = rv32i_types_pkg::alu_out_wb;
            2'd1:    sel = rv32i_types_pkg::br_en_wb;
            2'd2:    sel = rv32i_types_pkg::u_imm_wb;
            default: sel = rv32i_types_pkg::pc_plus4_wb;
        endcase
        case (t[31:29])
            3'd0, 3'd1: r = mem_rec(1'b1, op, a);
            3'd2, 3'd3: r = mem_rec(1'b0, op, a);
            3'd4: begin
                r    = mem_rec(t[23], op, a);
                r.pc = '0; // bubble.
            end
            default:    r = new_rec(sel, t[23]);
        endcase
        send_rec(r);
    endtask

    always @(negedge clk) begin
        case (stall_mode)
            1: wb_stall = 1'b1;
            2: begin
                stall_rng = xorshift32(stall_rng);
                wb_stall  = stall_rng[0];
            end
            default: wb_stall = 1'b0;
        endcase
    end

    // outputs are settled at the falling edge.
    always @(negedge clk) begin
        if (arst_n && wb_valid) begin
            checks++;
            if (exp_q.size() == 0) begin
                $display("write-back of order %0d in test %s was not expected", wb_order,
                         test_name);
                errors++;
            end else begin
                head = exp_q.pop_front();
                assert (wb_order == head.order)
                    else report_mismatch("order", head.order, wb_order);
                assert (wb_rd_s == head.rd_s)
                    else report_mismatch("rd_s", 64'(head.rd_s), 64'(wb_rd_s));
                assert (wb_rd_v == head.rd_v)
                    else report_mismatch("rd_v", 64'(head.rd_v), 64'(wb_rd_v));
                assert (wb_regf_we == head.regf_we)
                    else report_mismatch("regf_we", 64'(head.regf_we), 64'(wb_regf_we));
            end
        end else if (arst_n) begin
            assert (!wb_regf_we)
                else report_mismatch("regf_we idle", 64'd0, 64'(wb_regf_we));
        end
    end

    initial begin
        int                                accepted;
        logic [31:0]                       t;
        rv32i_types_pkg::word_t            addrs [8];
        pipe_cfg_pkg::ex_mem_stage_reg_t   r;
        arst_n   = 1'b0;
        ex_valid = 1'b0;
        ex_mem   = '0;
        for (int i = 0; i < pipe_cfg_pkg::DMEM_WORDS; i++) begin
            shadow[i] = '0;
        end
        repeat (8) @(negedge clk);
        arst_n = 1'b1;

        assert (ex_ready) else report_mismatch("ex_ready", 64'd1, 64'(ex_ready));
        assert (!wb_valid) else report_mismatch("wb_valid", 64'd0, 64'(wb_valid));
        assert (!wb_regf_we) else report_mismatch("wb_regf_we", 64'd0, 64'(wb_regf_we));

        test_name = "loads";
        for (int i = 0; i < 8; i++) begin
            t        = rand32();
            addrs[i] = {22'h0, t[9:2], 2'b00};
            send_rec(mem_rec(1'b1, rv32i_types_pkg::lw_mem, addrs[i]));
        end
        for (int i = 0; i < 8; i++) begin
            for (int k = 0; k < 4; k++) begin
                send_rec(mem_rec(1'b0, rv32i_types_pkg::lb_mem, addrs[i] + 32'(k)));
                send_rec(mem_rec(1'b0, rv32i_types_pkg::lbu_mem, addrs[i] + 32'(k)));
            end
            for (int k = 0; k < 4; k += 2) begin
                send_rec(mem_rec(1'b0, rv32i_types_pkg::lh_mem, addrs[i] + 32'(k)));
                send_rec(mem_rec(1'b0, rv32i_types_pkg::lhu_mem, addrs[i] + 32'(k)));
            end
            send_rec(mem_rec(1'b0, rv32i_types_pkg::lw_mem, addrs[i]));
        end
        drain();

        test_name = "sources";
        for (int we = 0; we < 2; we++) begin
            send_rec(new_rec(rv32i_types_pkg::alu_out_wb, we[0]));
            send_rec(new_rec(rv32i_types_pkg::br_en_wb, we[0]));
            send_rec(new_rec(rv32i_types_pkg::u_imm_wb, we[0]));
            send_rec(new_rec(rv32i_types_pkg::pc_plus4_wb, we[0]));
        end
        drain();

        test_name = "stores";
        send_rec(mem_rec(1'b1, rv32i_types_pkg::lb_mem, 32'h101));
        r    = new_rec(rv32i_types_pkg::alu_out_wb, 1'b1);
        r.pc = '0;
        send_rec(r);
        send_rec(mem_rec(1'b1, rv32i_types_pkg::lh_mem, 32'h102));
        send_rec(mem_rec(1'b0, rv32i_types_pkg::lw_mem, 32'h100));
        r    = mem_rec(1'b1, rv32i_types_pkg::lw_mem, 32'h100);
        r.pc = '0; // must leave memory alone.
        send_rec(r);
        send_rec(mem_rec(1'b0, rv32i_types_pkg::lw_mem, 32'h100));
        drain();

        test_name  = "backpressure";
        stall_mode = 1;
        accepted   = 0;
        while (ex_ready && accepted < 2 * DEPTH) begin
            send_rec(new_rec(rv32i_types_pkg::alu_out_wb, 1'b1));
            accepted++;
        end
        assert (accepted == DEPTH)
            else report_mismatch("accepts", 64'(DEPTH), 64'(accepted));
        drain();

        test_name  = "random";
        stall_mode = 2;
        for (int i = 0; i < 300; i++) begin
            send_random_op();
        end
        drain();

        finish_run();
    end

endmodule

`default_nettype wire
